// File: source/fp_add_pkg.sv
package fp_add_pkg;

    ////////////////////////////////////////
    // default widths (double precision)
    ////////////////////////////////////////

    // biased exponent field width
    localparam int EXP_WIDTH  = 11;

    // stored fraction width, hidden bit not included
    localparam int FRAC_WIDTH = 52;

    // extra low bits under the significand for guard, round and sticky
    // adder width is frac_width + hidden bit + carry + sign + GRS_WIDTH
    localparam int GRS_WIDTH  = 3;

    ////////////////////////////////////////
    // significand operation
    ////////////////////////////////////////

    // picked from the operand sign pair in the align stage
    // a+b for equal signs, a-b for (+a,-b), b-a for (-a,+b)
    typedef enum logic [1:0] {
        OP_A_ADD_B = 2'd0,
        OP_A_SUB_B = 2'd1,
        OP_B_SUB_A = 2'd2
    } sig_op_e;

endpackage

// File: source/fp_stage_if.sv
`timescale 1ns/10ps

// stage 1 to stage 2: split operands and exponent compare
interface unpacked_if
    import fp_add_pkg::*;
#(
    parameter int exp_width  = EXP_WIDTH,
    parameter int frac_width = FRAC_WIDTH
);
    logic                  valid;
    logic                  sign_a;
    logic                  sign_b;
    logic [exp_width-1:0]  exp_a;
    logic [exp_width-1:0]  exp_b;
    // significands with hidden bit restored
    logic [frac_width:0]   sig_a;
    logic [frac_width:0]   sig_b;
    logic                  a_exp_larger;
    logic [exp_width-1:0]  exp_diff;

    modport src (output valid, sign_a, sign_b, exp_a, exp_b, sig_a, sig_b,
                 a_exp_larger, exp_diff);
    modport snk (input  valid, sign_a, sign_b, exp_a, exp_b, sig_a, sig_b,
                 a_exp_larger, exp_diff);
endinterface

// stage 2 to stage 3: aligned significands in adder width
interface aligned_if
    import fp_add_pkg::*;
#(
    parameter int exp_width  = EXP_WIDTH,
    parameter int frac_width = FRAC_WIDTH
);
    logic                                 valid;
    sig_op_e                              op;
    logic                                 sign_a;
    logic                                 sign_b;
    logic [exp_width-1:0]                 exp;
    logic [frac_width+GRS_WIDTH+2:0]      sig_a;
    logic [frac_width+GRS_WIDTH+2:0]      sig_b;

    modport src (output valid, op, sign_a, sign_b, exp, sig_a, sig_b);
    modport snk (input  valid, op, sign_a, sign_b, exp, sig_a, sig_b);
endinterface

// stage 3 to stage 4: signed significand sum, msb is the sign
interface sum_if
    import fp_add_pkg::*;
#(
    parameter int exp_width  = EXP_WIDTH,
    parameter int frac_width = FRAC_WIDTH
);
    logic                                 valid;
    logic                                 sign_a;
    logic                                 sign_b;
    logic [exp_width-1:0]                 exp;
    logic [frac_width+GRS_WIDTH+2:0]      sum;

    modport src (output valid, sign_a, sign_b, exp, sum);
    modport snk (input  valid, sign_a, sign_b, exp, sum);
endinterface

// stage 4 to stage 5: normalized fraction plus rounding bits
interface normalized_if
    import fp_add_pkg::*;
#(
    parameter int exp_width  = EXP_WIDTH,
    parameter int frac_width = FRAC_WIDTH
);
    logic                   valid;
    logic                   sign;
    logic [exp_width-1:0]   exp;
    logic [frac_width-1:0]  frac;
    logic                   lsb;
    logic                   guard;
    logic                   round_bit;
    logic                   sticky;

    modport src (output valid, sign, exp, frac, lsb, guard, round_bit, sticky);
    modport snk (input  valid, sign, exp, frac, lsb, guard, round_bit, sticky);
endinterface

// File: source/fp_unpack.sv
`timescale 1ns/10ps

module fp_unpack
    import fp_add_pkg::*;
#(
    parameter int exp_width  = EXP_WIDTH,
    parameter int frac_width = FRAC_WIDTH
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [exp_width+frac_width:0] a,
    input  logic [exp_width+frac_width:0] b,
    input  logic                          in_valid,
    unpacked_if.src                       up
);

    logic [exp_width-1:0] exp_a;
    logic [exp_width-1:0] exp_b;
    logic                 a_larger;

    // field split, sign on top, fraction at the bottom
    assign exp_a    = a[exp_width+frac_width-1:frac_width];
    assign exp_b    = b[exp_width+frac_width-1:frac_width];
    // equal exponents go to the b side, diff is zero either way
    assign a_larger = exp_a > exp_b;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            up.valid        <= 1'b0;
            up.sign_a       <= 1'b0;
            up.sign_b       <= 1'b0;
            up.exp_a        <= '0;
            up.exp_b        <= '0;
            up.sig_a        <= '0;
            up.sig_b        <= '0;
            up.a_exp_larger <= 1'b0;
            up.exp_diff     <= '0;
        end else begin
            up.valid        <= in_valid;
            up.sign_a       <= a[exp_width+frac_width];
            up.sign_b       <= b[exp_width+frac_width];
            up.exp_a        <= exp_a;
            up.exp_b        <= exp_b;
            // hidden bit only for a nonzero exponent, so zero stays zero
            up.sig_a        <= {|exp_a, a[frac_width-1:0]};
            up.sig_b        <= {|exp_b, b[frac_width-1:0]};
            up.a_exp_larger <= a_larger;
            up.exp_diff     <= a_larger ? (exp_a - exp_b) : (exp_b - exp_a);
        end
    end

endmodule

// File: source/fp_align.sv
`timescale 1ns/10ps

module fp_align
    import fp_add_pkg::*;
#(
    parameter int exp_width  = EXP_WIDTH,
    parameter int frac_width = FRAC_WIDTH
) (
    input  logic    clk,
    input  logic    rst_n,
    unpacked_if.snk up,
    aligned_if.src  al
);

    // sign, carry, hidden + fraction, guard/round/sticky
    localparam int aw = frac_width + GRS_WIDTH + 3;

    logic [aw-1:0] ext_a;
    logic [aw-1:0] ext_b;
    logic [aw-1:0] small_ext;
    logic [aw-1:0] lost_mask;
    logic [aw-1:0] shifted;
    logic          sticky;
    sig_op_e       op;

    ////////////////////////////////////////
    // alignment shift
    ////////////////////////////////////////

    // two zero top bits, grs bits zero below
    assign ext_a     = {2'b00, up.sig_a, {GRS_WIDTH{1'b0}}};
    assign ext_b     = {2'b00, up.sig_b, {GRS_WIDTH{1'b0}}};
    assign small_ext = up.a_exp_larger ? ext_b : ext_a;

    // mask of the bits that drop off the low end, all ones past aw
    assign lost_mask = ~({aw{1'b1}} << up.exp_diff);
    assign sticky    = |(small_ext & lost_mask);
    // lost bits fold into bit 0 as sticky
    assign shifted   = (small_ext >> up.exp_diff) | {{(aw-1){1'b0}}, sticky};

    ////////////////////////////////////////
    // operation from the sign pair
    ////////////////////////////////////////

    always_comb begin
        case ({up.sign_a, up.sign_b})
            2'b01:   op = OP_A_SUB_B;
            2'b10:   op = OP_B_SUB_A;
            default: op = OP_A_ADD_B;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            al.valid  <= 1'b0;
            al.op     <= OP_A_ADD_B;
            al.sign_a <= 1'b0;
            al.sign_b <= 1'b0;
            al.exp    <= '0;
            al.sig_a  <= '0;
            al.sig_b  <= '0;
        end else begin
            al.valid  <= up.valid;
            al.op     <= op;
            al.sign_a <= up.sign_a;
            al.sign_b <= up.sign_b;
            // larger exponent is the result exponent before normalization
            al.exp    <= up.a_exp_larger ? up.exp_a : up.exp_b;
            al.sig_a  <= up.a_exp_larger ? ext_a : shifted;
            al.sig_b  <= up.a_exp_larger ? shifted : ext_b;
        end
    end

endmodule

// File: source/fp_mantissa_add.sv
`timescale 1ns/10ps

module fp_mantissa_add
    import fp_add_pkg::*;
#(
    parameter int exp_width  = EXP_WIDTH,
    parameter int frac_width = FRAC_WIDTH
) (
    input  logic    clk,
    input  logic    rst_n,
    aligned_if.snk  al,
    sum_if.src      sm
);

    localparam int aw = frac_width + GRS_WIDTH + 3;

    logic [aw-1:0] sum;

    // two's complement in aw bits, top bit ends up as the sign
    always_comb begin
        case (al.op)
            OP_A_SUB_B: sum = al.sig_a - al.sig_b;
            OP_B_SUB_A: sum = al.sig_b - al.sig_a;
            default:    sum = al.sig_a + al.sig_b;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sm.valid  <= 1'b0;
            sm.sign_a <= 1'b0;
            sm.sign_b <= 1'b0;
            sm.exp    <= '0;
            sm.sum    <= '0;
        end else begin
            sm.valid  <= al.valid;
            sm.sign_a <= al.sign_a;
            sm.sign_b <= al.sign_b;
            sm.exp    <= al.exp;
            sm.sum    <= sum;
        end
    end

endmodule

// File: source/fp_normalize.sv
`timescale 1ns/10ps

module fp_normalize
    import fp_add_pkg::*;
#(
    parameter int exp_width  = EXP_WIDTH,
    parameter int frac_width = FRAC_WIDTH
) (
    input  logic        clk,
    input  logic        rst_n,
    sum_if.snk          sm,
    normalized_if.src   nm
);

    localparam int aw  = frac_width + GRS_WIDTH + 3;
    // magnitude width, sign bit dropped, msb is the carry position
    localparam int nw  = aw - 1;
    localparam int lzw = $clog2(nw + 1);

    logic          neg;
    logic [aw-1:0] mag_full;
    logic [nw-1:0] mag;
    logic [nw-1:0] norm;
    logic [lzw-1:0] lz;
    logic          zero;
    logic          sign;

    ////////////////////////////////////////
    // magnitude and leading zero count
    ////////////////////////////////////////

    assign neg      = sm.sum[aw-1];
    assign mag_full = neg ? (~sm.sum + {{(aw-1){1'b0}}, 1'b1}) : sm.sum;
    assign mag      = mag_full[nw-1:0];
    assign zero     = ~|mag;

    // priority scan, the highest set bit wins
    always_comb begin
        lz = '0;
        for (int i = 0; i < nw; i++) begin
            if (mag[i]) begin
                lz = lzw'(nw - 1 - i);
            end
        end
    end

    // leading one lands on the carry position
    // a carry result needs no shift, its bit 0 goes into sticky
    assign norm = mag << lz;

    // result sign
    always_comb begin
        if (zero) begin
            // exact cancellation gives +0, only -0 + -0 stays negative
            sign = sm.sign_a & sm.sign_b;
        end else if (sm.sign_a == sm.sign_b) begin
            sign = sm.sign_a;
        end else begin
            sign = neg;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            nm.valid     <= 1'b0;
            nm.sign      <= 1'b0;
            nm.exp       <= '0;
            nm.frac      <= '0;
            nm.lsb       <= 1'b0;
            nm.guard     <= 1'b0;
            nm.round_bit <= 1'b0;
            nm.sticky    <= 1'b0;
        end else begin
            nm.valid     <= sm.valid;
            nm.sign      <= sign;
            // leading one one above hidden means +1, each left shift -1
            nm.exp       <= zero ? '0 : (sm.exp + exp_width'(1) - exp_width'(lz));
            // fraction sits just below the leading one
            nm.frac      <= norm[nw-2 -: frac_width];
            nm.lsb       <= norm[GRS_WIDTH+1];
            nm.guard     <= norm[GRS_WIDTH];
            nm.round_bit <= norm[GRS_WIDTH-1];
            nm.sticky    <= |norm[GRS_WIDTH-2:0];
        end
    end

endmodule

// File: source/fp_round.sv
`timescale 1ns/10ps

module fp_round
    import fp_add_pkg::*;
#(
    parameter int exp_width  = EXP_WIDTH,
    parameter int frac_width = FRAC_WIDTH
) (
    input  logic                          clk,
    input  logic                          rst_n,
    normalized_if.snk                     nm,
    output logic [exp_width+frac_width:0] result,
    output logic                          out_valid
);

    logic                  round_up;
    logic [frac_width+1:0] sig_rnd;
    logic                  carry;
    logic [frac_width-1:0] frac_out;
    logic [exp_width-1:0]  exp_out;

    // nearest even: above half, or exactly half with odd lsb
    assign round_up = nm.guard & (nm.round_bit | nm.sticky | nm.lsb);

    // spare top bit and hidden one, so the carry out shows up on top
    assign sig_rnd  = {2'b01, nm.frac} + {{(frac_width+1){1'b0}}, round_up};
    assign carry    = sig_rnd[frac_width+1];

    // 1.111..1 + ulp -> 10.000..0, shift right once and bump exponent
    assign frac_out = carry ? sig_rnd[frac_width:1] : sig_rnd[frac_width-1:0];
    assign exp_out  = nm.exp + {{(exp_width-1){1'b0}}, carry};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            result    <= '0;
        end else begin
            out_valid <= nm.valid;
            result    <= {nm.sign, exp_out, frac_out};
        end
    end

endmodule

// File: source/fp_add.sv
`timescale 1ns/10ps

module fp_add
    import fp_add_pkg::*;
#(
    parameter int exp_width  = EXP_WIDTH,
    parameter int frac_width = FRAC_WIDTH
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [exp_width+frac_width:0] a,
    input  logic [exp_width+frac_width:0] b,
    input  logic                          in_valid,
    output logic [exp_width+frac_width:0] result,
    output logic                          out_valid
);

    ////////////////////////////////////////
    // stage links
    ////////////////////////////////////////

    unpacked_if   #(.exp_width(exp_width), .frac_width(frac_width)) up_if ();
    aligned_if    #(.exp_width(exp_width), .frac_width(frac_width)) al_if ();
    sum_if        #(.exp_width(exp_width), .frac_width(frac_width)) sm_if ();
    normalized_if #(.exp_width(exp_width), .frac_width(frac_width)) nm_if ();

    ////////////////////////////////////////
    // five stage chain, one register each
    ////////////////////////////////////////

    // stage 1, split and exponent compare
    fp_unpack #(.exp_width(exp_width), .frac_width(frac_width)) unpack_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .a        (a),
        .b        (b),
        .in_valid (in_valid),
        .up       (up_if.src)
    );

    // stage 2, alignment shift with sticky
    fp_align #(.exp_width(exp_width), .frac_width(frac_width)) align_i (
        .clk   (clk),
        .rst_n (rst_n),
        .up    (up_if.snk),
        .al    (al_if.src)
    );

    // stage 3, significand add or subtract
    fp_mantissa_add #(.exp_width(exp_width), .frac_width(frac_width)) add_i (
        .clk   (clk),
        .rst_n (rst_n),
        .al    (al_if.snk),
        .sm    (sm_if.src)
    );

    // stage 4, normalization
    fp_normalize #(.exp_width(exp_width), .frac_width(frac_width)) normalize_i (
        .clk   (clk),
        .rst_n (rst_n),
        .sm    (sm_if.snk),
        .nm    (nm_if.src)
    );

    // stage 5, rounding and packing
    fp_round #(.exp_width(exp_width), .frac_width(frac_width)) round_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .nm        (nm_if.snk),
        .result    (result),
        .out_valid (out_valid)
    );

endmodule

// File: test/fp_add_tb.sv
`timescale 1ns/10ps

module fp_add_tb;

    localparam int num_directed = 20;
    localparam int num_random   = 2000;
    // at most one bubble per random op, plus reset and drain slack
    localparam int max_cycles   = 2 * (num_directed + num_random) + 40;

    // operand pairs {a, b}, sent back to back so five are in flight
    localparam logic [127:0] directed_ops [num_directed] = '{
        {64'h3FF0000000000000, 64'h3FF0000000000000}, // 1 + 1
        {64'h3FF8000000000000, 64'h3F50000000000000}, // 1.5 + 2^-10
        {64'h3FF0000000000000, 64'h3C30000000000000}, // diff 60, past adder width
        {64'h3FF0000000000000, 64'h3CA8000000000000}, // just above tie
        {64'h3FF0000000000000, 64'h3CA0000000000000}, // tie, even lsb stays
        {64'h3FF0000000000001, 64'h3CA0000000000000}, // tie, odd lsb rounds up
        {64'h3FFFFFFFFFFFFFFF, 64'h3CA0000000000000}, // round carry to 2.0
        {64'h3FF0000000000000, 64'hBFEFFFFFFFFFFFFF}, // 1 - (1 - 2^-53)
        {64'h3FF0000000000001, 64'hBFF0000000000000}, // near total cancellation
        {64'hC008000000000000, 64'h3FF0000000000000}, // -3 + 1
        {64'h3FF0000000000000, 64'hBAF0000000000000}, // 1 - 2^-80, sticky only
        {64'h3FF0000000000000, 64'hBC90000000000000}, // 1 - 2^-54, tie below 1
        {64'h3FF8000000000000, 64'hBFF4000000000000}, // 1.5 - 1.25
        {64'h3FB999999999999A, 64'hBFB999999999999A}, // x + (-x)
        {64'h8000000000000000, 64'h8000000000000000}, // -0 + -0
        {64'h0000000000000000, 64'h8000000000000000}, // +0 + -0
        {64'h0000000000000000, 64'h400921FB54442D18}, // 0 + y
        {64'h400921FB54442D18, 64'h8000000000000000}, // y + -0
        {64'h3FF0000000000000, 64'hBFF0000000000000}, // 1 - 1
        {64'hC008000000000000, 64'hC008000000000000}  // -3 + -3
    };

    logic        clk;
    logic        rst_n;
    logic [63:0] a;
    logic [63:0] b;
    logic        in_valid;
    logic [63:0] result;
    logic        out_valid;

    int          cycle       = 0;
    logic [31:0] lcg_state   = 32'h897e;

    // scoreboard, expected word and the cycle its input was seen
    logic [63:0] exp_q[$];
    int          cyc_q[$];

    fp_add dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .a         (a),
        .b         (b),
        .in_valid  (in_valid),
        .result    (result),
        .out_valid (out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////
    // reference model and helpers
    ////////////////////////////////////////

    // host double add is IEEE nearest even, -0 + -0 stays -0
    function automatic logic [63:0] ref_add(input logic [63:0] x, input logic [63:0] y);
        real sum;
        sum = $bitstoreal(x) + $bitstoreal(y);
        return $realtobits(sum);
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic report_error(input string msg);
        $display("ERROR: %s at cycle %0d", msg, cycle);
        $display("STATUS: FAIL");
        $fatal(1, "%s", msg);
    endtask

    // normal operand, biased exponent 900 to 1100, sometimes a signed zero
    task automatic rand_operand(output logic [63:0] op);
        logic [31:0] r0;
        logic [31:0] r1;
        logic [10:0] e;
        lcg_state = lcg_next(lcg_state);
        r0 = lcg_state;
        lcg_state = lcg_next(lcg_state);
        r1 = lcg_state;
        e = 11'd900 + (r0[30:20] % 11'd201);
        if (r1[31:28] == 4'h0) begin
            op = {r0[31], 63'd0};
        end else begin
            op = {r0[31], e, r0[19:0], r1};
        end
    endtask

    task automatic drive_op(input logic [63:0] op_a, input logic [63:0] op_b);
        @(posedge clk);
        a        <= op_a;
        b        <= op_b;
        in_valid <= 1'b1;
    endtask

    task automatic drive_bubble();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    initial begin : stimulus
        logic [63:0] op_a;
        logic [63:0] op_b;
        rst_n    = 1'b0;
        a        = '0;
        b        = '0;
        in_valid = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < num_directed; i++) begin
            drive_op(directed_ops[i][127:64], directed_ops[i][63:0]);
        end

        for (int i = 0; i < num_random; i++) begin
            rand_operand(op_a);
            rand_operand(op_b);
            lcg_state = lcg_next(lcg_state);
            // same exponent for deep cancellation, or an exact negation
            if (lcg_state[31:29] == 3'd0 && op_a[62:52] != 11'd0) begin
                op_b[62:52] = op_a[62:52];
            end else if (lcg_state[31:29] == 3'd1) begin
                op_b = {~op_a[63], op_a[62:0]};
            end
            // upper lcg bits, the low ones repeat every four steps
            if (lcg_state[17:16] == 2'd0) begin
                drive_bubble();
            end
            drive_op(op_a, op_b);
        end
        drive_bubble();

        // drain, then watch a few more cycles for stray pulses
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (8) @(posedge clk);

        $display("STATUS: PASS");
        $finish;
    end

    ////////////////////////////////////////
    // scoreboard and watchdog
    ////////////////////////////////////////

    // negedge sampling, everything is settled half a period after the edge
    always @(negedge clk) begin : compare
        logic [63:0] expected;
        int          in_cycle;
        if (out_valid) begin
            if (exp_q.size() == 0) begin
                report_error("out_valid high with no result pending");
            end else begin
                expected = exp_q.pop_front();
                in_cycle = cyc_q.pop_front();
                check_value("result", expected, result);
                check_value("latency", 64'd5, 64'(cycle - in_cycle));
            end
        end else if (cyc_q.size() != 0 && cycle - cyc_q[0] >= 5) begin
            report_error("result missing 5 cycles after its input");
        end
        if (in_valid) begin
            exp_q.push_back(ref_add(a, b));
            cyc_q.push_back(cycle);
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= max_cycles) begin
            $display("ERROR: run did not finish within %0d cycles", max_cycles);
            $display("STATUS: FAIL");
            $fatal(1, "timeout");
        end
    end

endmodule

// File: fp_add.f
source/fp_add_pkg.sv
source/fp_stage_if.sv
source/fp_unpack.sv
source/fp_align.sv
source/fp_mantissa_add.sv
source/fp_normalize.sv
source/fp_round.sv
source/fp_add.sv
test/fp_add_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the fp_add testbench with Verilator, run it, and check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module fp_add_tb -f fp_add.f -o fp_add_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/fp_add_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^STATUS: PASS$" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1
